// ==== filelist.f ====
hw/hmem_pkg.sv
hw/wr_burst_splitter.sv
hw/wr_beat_fifo.sv
hw/host_wr_channel.sv
hw/hmem_wr_top.sv
sim/hmem_wr_sva.sv
sim/tb_hmem_wr.sv

// ==== hw/hmem_pkg.sv ====
/*
 * Shared widths and vector types for the host write path,
 * the burst splitter state encoding and the beat FIFO depth
 */

package hmem_pkg;

    // ============================================================
    // Line addressing and payload
    // ============================================================

    // Host memory is addressed in whole lines
    localparam int LINE_ADDR_W = 16;
    typedef logic [LINE_ADDR_W-1:0] t_line_addr;

    // A real host line is 512 bits, kept narrow here for simulation speed
    localparam int LINE_DATA_W = 64;
    typedef logic [LINE_DATA_W-1:0] t_line_data;

    // ============================================================
    // Burst and chunk sizes
    // ============================================================

    // AFU bursts run from 1 to 16 lines, so the count needs 5 bits
    localparam int AFU_BURST_W = 5;
    typedef logic [AFU_BURST_W-1:0] t_afu_burst;

    // Host chunks hold 1, 2 or 4 lines
    // The length field holds the line count minus one (0, 1 or 3)
    localparam int CL_LEN_W = 2;
    typedef logic [CL_LEN_W-1:0] t_cl_len;

    // Position of a beat inside a host chunk, 0 to 3
    typedef logic [CL_LEN_W-1:0] t_cl_num;

    // ============================================================
    // Buffering and control
    // ============================================================

    // Default number of beats held between the splitter and the channel
    localparam int BEAT_FIFO_DEPTH = 8;

    // SPLIT_START means the next AFU beat opens a new AFU burst
    // SPLIT_CHUNK means the splitter is part way through an AFU burst
    typedef enum logic
    {
        SPLIT_START = 1'b0,
        SPLIT_CHUNK = 1'b1
    } t_split_state;

endpackage

// ==== hw/hmem_wr_top.sv ====
/*
 * Host memory write path top level. AFU bursts pass through the
 * splitter, a beat FIFO and the host write channel
 */

`timescale 1ns/1ps

module hmem_wr_top import hmem_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // AFU write port
    input  logic         wr_write,
    input  t_line_addr   wr_address,
    input  t_afu_burst   wr_burstcount,
    input  t_line_data   wr_writedata,
    input  logic         wr_function,
    output logic         wr_waitrequest,
    output logic         wr_writeresponsevalid,

    // Host write channel
    output logic         c1_valid,
    output t_line_addr   c1_address,
    output t_cl_len      c1_cl_len,
    output logic         c1_sop,
    output logic         c1_fence,
    output t_line_data   c1_data,
    output logic         c1_mdata,
    input  logic         c1_almfull,
    input  logic         c1_rsp_valid,
    input  logic         c1_rsp_mdata
);

    // Splitter to FIFO
    logic       beat_valid;
    logic       beat_ready;
    t_line_addr beat_addr;
    t_cl_len    beat_len;
    logic       beat_fence;
    logic       beat_rsp;
    t_line_data beat_data;

    // FIFO to host channel
    logic       q_valid;
    logic       q_ready;
    t_line_addr q_addr;
    t_cl_len    q_len;
    logic       q_fence;
    logic       q_rsp;
    t_line_data q_data;

    wr_burst_splitter u_splitter
    (
        .clk            (clk),
        .reset          (reset),
        .wr_write       (wr_write),
        .wr_address     (wr_address),
        .wr_burstcount  (wr_burstcount),
        .wr_writedata   (wr_writedata),
        .wr_function    (wr_function),
        .wr_waitrequest (wr_waitrequest),
        .beat_ready     (beat_ready),
        .beat_valid     (beat_valid),
        .beat_addr      (beat_addr),
        .beat_len       (beat_len),
        .beat_fence     (beat_fence),
        .beat_rsp       (beat_rsp),
        .beat_data      (beat_data)
    );

    // Absorbs host back-pressure so the AFU sees waitrequest only when full
    wr_beat_fifo #(.DEPTH(BEAT_FIFO_DEPTH)) u_fifo
    (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (beat_valid),
        .in_addr   (beat_addr),
        .in_len    (beat_len),
        .in_fence  (beat_fence),
        .in_rsp    (beat_rsp),
        .in_data   (beat_data),
        .in_ready  (beat_ready),
        .out_ready (q_ready),
        .out_valid (q_valid),
        .out_addr  (q_addr),
        .out_len   (q_len),
        .out_fence (q_fence),
        .out_rsp   (q_rsp),
        .out_data  (q_data)
    );

    host_wr_channel u_channel
    (
        .clk                   (clk),
        .reset                 (reset),
        .q_valid               (q_valid),
        .q_addr                (q_addr),
        .q_len                 (q_len),
        .q_fence               (q_fence),
        .q_rsp                 (q_rsp),
        .q_data                (q_data),
        .q_ready               (q_ready),
        .c1_almfull            (c1_almfull),
        .c1_valid              (c1_valid),
        .c1_address            (c1_address),
        .c1_cl_len             (c1_cl_len),
        .c1_sop                (c1_sop),
        .c1_fence              (c1_fence),
        .c1_data               (c1_data),
        .c1_mdata              (c1_mdata),
        .c1_rsp_valid          (c1_rsp_valid),
        .c1_rsp_mdata          (c1_rsp_mdata),
        .wr_writeresponsevalid (wr_writeresponsevalid)
    );

endmodule

// ==== hw/host_wr_channel.sv ====
/*
 * Host write channel. Turns queued beats into host write beats
 * with chunk headers, stalls on almost-full and forwards the
 * write responses that the AFU is waiting for
 */

`timescale 1ns/1ps

module host_wr_channel import hmem_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // Beats from the FIFO
    input  logic         q_valid,
    input  t_line_addr   q_addr,
    input  t_cl_len      q_len,
    input  logic         q_fence,
    input  logic         q_rsp,
    input  t_line_data   q_data,
    output logic         q_ready,

    // Host write request channel
    input  logic         c1_almfull,
    output logic         c1_valid,
    output t_line_addr   c1_address,
    output t_cl_len      c1_cl_len,
    output logic         c1_sop,
    output logic         c1_fence,
    output t_line_data   c1_data,
    output logic         c1_mdata,

    // Host write responses and the AFU response strobe
    input  logic         c1_rsp_valid,
    input  logic         c1_rsp_mdata,
    output logic         wr_writeresponsevalid
);

    logic    stall;
    logic    pop;

    // Start flag and beat index of the chunk now being issued
    logic    wr_sop;
    logic    wr_eop;
    t_cl_num wr_cl_num;
    t_cl_num wr_cl_addr;

    // ============================================================
    // Flow control
    // ============================================================

    // Almost-full is registered once, so a raised almfull stops new
    // beats from the second edge on
    always_ff @(posedge clk)
    begin
        stall <= c1_almfull;

        if (reset)
        begin
            stall <= 1'b0;
        end
    end

    assign q_ready = !stall;
    assign pop = q_valid && !stall;

    // A chunk ends on the beat whose index reaches its length
    assign wr_eop = (wr_cl_num == t_cl_num'(q_len));

    // ============================================================
    // Host write beats
    // ============================================================

    always_ff @(posedge clk)
    begin
        c1_valid <= pop;

        if (pop)
        begin
            c1_data <= q_data;

            if (wr_sop)
            begin
                // Header beat carries the chunk start and response request
                c1_sop <= 1'b1;
                c1_fence <= q_fence;
                c1_mdata <= q_rsp;
                wr_cl_addr <= t_cl_num'(q_addr[1:0]);

                // A fence has no address or length on the host side
                if (q_fence)
                begin
                    c1_address <= t_line_addr'(0);
                    c1_cl_len <= t_cl_len'(0);
                end
                else
                begin
                    c1_address <= q_addr;
                    c1_cl_len <= q_len;
                end
            end
            else
            begin
                // Later beats step through the low address bits of the chunk
                c1_address[1:0] <= wr_cl_addr | wr_cl_num;
                c1_sop <= 1'b0;
            end

            if (wr_eop)
            begin
                wr_sop <= 1'b1;
                wr_cl_num <= t_cl_num'(0);
            end
            else
            begin
                wr_sop <= 1'b0;
                wr_cl_num <= wr_cl_num + t_cl_num'(1);
            end
        end

        if (reset)
        begin
            c1_valid <= 1'b0;
            wr_sop <= 1'b1;
            wr_cl_num <= t_cl_num'(0);
        end
    end

    // ============================================================
    // Write responses
    // ============================================================

    // mdata bit set means the chunk closed an AFU burst
    always_ff @(posedge clk)
    begin
        wr_writeresponsevalid <= c1_rsp_valid && c1_rsp_mdata;

        if (reset)
        begin
            wr_writeresponsevalid <= 1'b0;
        end
    end

endmodule

// ==== hw/wr_beat_fifo.sv ====
/*
 * Synchronous valid/ready FIFO for split write beats, holding
 * chunk header fields alongside each line of data
 */

`timescale 1ns/1ps

module wr_beat_fifo import hmem_pkg::*;
#(
    parameter int DEPTH = BEAT_FIFO_DEPTH
)
(
    input  logic         clk,
    input  logic         reset,

    input  logic         in_valid,
    input  t_line_addr   in_addr,
    input  t_cl_len      in_len,
    input  logic         in_fence,
    input  logic         in_rsp,
    input  t_line_data   in_data,
    output logic         in_ready,

    input  logic         out_ready,
    output logic         out_valid,
    output t_line_addr   out_addr,
    output t_cl_len      out_len,
    output logic         out_fence,
    output logic         out_rsp,
    output t_line_data   out_data
);

    typedef logic [$clog2(DEPTH)-1:0] t_ptr;
    typedef logic [$clog2(DEPTH+1)-1:0] t_count;

    // Storage, one entry per beat
    t_line_addr mem_addr  [DEPTH];
    t_cl_len    mem_len   [DEPTH];
    logic       mem_fence [DEPTH];
    logic       mem_rsp   [DEPTH];
    t_line_data mem_data  [DEPTH];

    t_ptr   wr_ptr;
    t_ptr   rd_ptr;
    t_count count;

    logic push;
    logic pop;

    // Full blocks the producer, empty hides the head entry
    assign in_ready = (count != t_count'(DEPTH));
    assign out_valid = (count != t_count'(0));

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    // Head of the queue drives the consumer without a register stage
    assign out_addr = mem_addr[rd_ptr];
    assign out_len = mem_len[rd_ptr];
    assign out_fence = mem_fence[rd_ptr];
    assign out_rsp = mem_rsp[rd_ptr];
    assign out_data = mem_data[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem_addr[wr_ptr] <= in_addr;
            mem_len[wr_ptr] <= in_len;
            mem_fence[wr_ptr] <= in_fence;
            mem_rsp[wr_ptr] <= in_rsp;
            mem_data[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap explicitly so that any depth works
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            wr_ptr <= (wr_ptr == t_ptr'(DEPTH - 1)) ? t_ptr'(0) : wr_ptr + t_ptr'(1);
        end

        if (pop)
        begin
            rd_ptr <= (rd_ptr == t_ptr'(DEPTH - 1)) ? t_ptr'(0) : rd_ptr + t_ptr'(1);
        end

        // A push and a pop in the same cycle leave the count unchanged
        if (push && !pop)
        begin
            count <= count + t_count'(1);
        end
        else if (pop && !push)
        begin
            count <= count - t_count'(1);
        end

        if (reset)
        begin
            wr_ptr <= t_ptr'(0);
            rd_ptr <= t_ptr'(0);
            count <= t_count'(0);
        end
    end

endmodule

// ==== hw/wr_burst_splitter.sv ====
/*
 * AFU write burst splitter. Cuts bursts of up to 16 lines into
 * naturally aligned host chunks of 1, 2 or 4 lines and tags the
 * chunk that closes each AFU burst as expecting a response
 */

`timescale 1ns/1ps

module wr_burst_splitter import hmem_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // AFU write port with waitrequest flow control
    input  logic         wr_write,
    input  t_line_addr   wr_address,
    input  t_afu_burst   wr_burstcount,
    input  t_line_data   wr_writedata,
    input  logic         wr_function,
    output logic         wr_waitrequest,

    // Split beats toward the FIFO
    input  logic         beat_ready,
    output logic         beat_valid,
    output t_line_addr   beat_addr,
    output t_cl_len      beat_len,
    output logic         beat_fence,
    output logic         beat_rsp,
    output t_line_data   beat_data
);

    t_split_state state;

    // Position inside the AFU burst, valid while in SPLIT_CHUNK
    t_line_addr   cur_addr;
    t_afu_burst   lines_left;

    // Header of the chunk being emitted and the next beat index in it
    t_cl_num      beat_idx;
    t_line_addr   chunk_base;
    t_cl_len      chunk_len;
    logic         chunk_rsp;

    // Values seen by the beat now on the AFU port
    logic         first_beat;
    logic         chunk_start;
    t_line_addr   addr_now;
    t_afu_burst   rem_now;
    t_cl_len      rule_len;
    t_cl_len      len_now;
    t_cl_num      idx_now;
    logic         chunk_end;
    logic         take;

    // ============================================================
    // Chunk selection
    // ============================================================

    // The first beat of an AFU burst carries the address and count
    // Later beats run from the tracked position instead
    assign first_beat = (state == SPLIT_START);
    assign addr_now = first_beat ? wr_address : cur_addr;

    // A fence always counts as a single line
    assign rem_now = first_beat ? (wr_function ? t_afu_burst'(1) : wr_burstcount) : lines_left;

    // A new chunk opens at every burst start and after each chunk ends
    assign chunk_start = first_beat || (beat_idx == t_cl_num'(0));

    // Largest naturally aligned chunk that still fits in the burst
    always_comb
    begin
        if ((addr_now[1:0] == 2'b00) && (rem_now >= t_afu_burst'(4)))
        begin
            rule_len = t_cl_len'(3);
        end
        else if (!addr_now[0] && (rem_now >= t_afu_burst'(2)))
        begin
            rule_len = t_cl_len'(1);
        end
        else
        begin
            rule_len = t_cl_len'(0);
        end
    end

    assign len_now = chunk_start ? rule_len : chunk_len;
    assign idx_now = chunk_start ? t_cl_num'(0) : beat_idx;
    assign chunk_end = (idx_now == t_cl_num'(len_now));

    // ============================================================
    // Beat output
    // ============================================================

    // The splitter adds no storage, so the AFU sees the FIFO's ready directly
    assign beat_valid = wr_write;
    assign wr_waitrequest = !beat_ready;
    assign take = wr_write && beat_ready;

    assign beat_addr = chunk_start ? addr_now : chunk_base;
    assign beat_len = len_now;
    assign beat_fence = wr_function;
    assign beat_data = wr_writedata;

    // Only the chunk holding the last remaining lines earns a response
    assign beat_rsp = chunk_start ? (rem_now == t_afu_burst'(rule_len) + t_afu_burst'(1))
                                  : chunk_rsp;

    // ============================================================
    // Burst tracking
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            cur_addr <= addr_now + t_line_addr'(1);
            lines_left <= rem_now - t_afu_burst'(1);

            // Hold the header so every beat of the chunk repeats it
            if (chunk_start)
            begin
                chunk_base <= addr_now;
                chunk_len <= rule_len;
                chunk_rsp <= beat_rsp;
            end

            if (chunk_end)
            begin
                beat_idx <= t_cl_num'(0);
            end
            else
            begin
                beat_idx <= idx_now + t_cl_num'(1);
            end

            // Back to SPLIT_START once the last line of the burst is taken
            if (rem_now == t_afu_burst'(1))
            begin
                state <= SPLIT_START;
            end
            else
            begin
                state <= SPLIT_CHUNK;
            end
        end

        if (reset)
        begin
            state <= SPLIT_START;
            beat_idx <= t_cl_num'(0);
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the host write path testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_hmem_wr -o tb_hmem_wr
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# Assertion errors are counted by the testbench, so keep running past them
./obj_dir/tb_hmem_wr +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// ==== sim/hmem_wr_sva.sv ====
/*
 * Host write channel protocol assertions, bound into the top level
 */

`timescale 1ns/1ps

module hmem_wr_sva import hmem_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       c1_valid,
    input t_line_addr c1_address,
    input t_cl_len    c1_cl_len,
    input logic       c1_sop,
    input logic       c1_fence,
    input logic       c1_almfull,
    input logic       c1_rsp_valid,
    input logic       c1_rsp_mdata,
    input logic       wr_writeresponsevalid
);

    // Number of failed assertions so far
    int fail_count = 0;

    // ============================================================
    // Request channel
    // ============================================================

    // A chunk header sits on a line that is a multiple of the chunk size
    a_sop_aligned: assert property (@(posedge clk) disable iff (reset)
        (c1_valid && c1_sop && !c1_fence) |-> ((c1_address[1:0] & c1_cl_len) == 2'b00))
    else
    begin
        fail_count = fail_count + 1;
        $error("host chunk start is not aligned to its length");
    end

    // The host knows 1, 2 and 4 line chunks, so length code 2 never appears
    a_cl_len_legal: assert property (@(posedge clk) disable iff (reset)
        c1_valid |-> (c1_cl_len != 2'd2))
    else
    begin
        fail_count = fail_count + 1;
        $error("host beat carries a 3-line length code");
    end

    // Two edges of almfull leave the stall register set for the pop cycle
    a_almfull_stall: assert property (@(posedge clk) disable iff (reset)
        ($past(c1_almfull) && $past(c1_almfull, 2)) |-> !c1_valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("host beat issued after almfull was high for two edges");
    end

    // ============================================================
    // Responses and reset
    // ============================================================

    a_rsp_forward: assert property (@(posedge clk) disable iff (reset)
        (c1_rsp_valid && c1_rsp_mdata) |=> wr_writeresponsevalid)
    else
    begin
        fail_count = fail_count + 1;
        $error("host response with mdata set was not forwarded");
    end

    a_rsp_cause: assert property (@(posedge clk) disable iff (reset)
        wr_writeresponsevalid |-> $past(c1_rsp_valid && c1_rsp_mdata))
    else
    begin
        fail_count = fail_count + 1;
        $error("AFU write response without a matching host response");
    end

    a_reset_quiet: assert property (@(posedge clk)
        $past(reset) |-> !c1_valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("host beat valid while in reset");
    end

endmodule

// ==== sim/tb_hmem_wr.sv ====
/*
 * Testbench for the host write path. AFU burst driver, host model
 * with delayed responses and random almost-full, beat scoreboard
 */

`timescale 1ns/1ps

module tb_hmem_wr import hmem_pkg::*;
();

    // Wait loop limits in clock cycles and the random burst count
    localparam int WAIT_LIMIT  = 400;
    localparam int DRAIN_LIMIT = 2000;
    localparam int RAND_BURSTS = 24;

    logic       clk = 1'b0;
    logic       reset;
    logic       wr_write;
    t_line_addr wr_address;
    t_afu_burst wr_burstcount;
    t_line_data wr_writedata;
    logic       wr_function;
    logic       wr_waitrequest;
    logic       wr_writeresponsevalid;
    logic       c1_valid;
    t_line_addr c1_address;
    t_cl_len    c1_cl_len;
    logic       c1_sop;
    logic       c1_fence;
    t_line_data c1_data;
    logic       c1_mdata;
    logic       c1_almfull = 1'b0;
    logic       c1_rsp_valid = 1'b0;
    logic       c1_rsp_mdata = 1'b0;

    int seed = 32'h8ace;

    // Expected host beats, one entry per line, in issue order
    t_line_addr exp_addr[$];
    t_cl_len    exp_len[$];
    bit         exp_sop[$];
    bit         exp_fence[$];
    bit         exp_mdata[$];
    t_line_data exp_data[$];

    // Host responses waiting for their due cycle
    bit pend_mdata[$];
    int pend_due[$];

    // Next host inputs, chosen at the falling edge and driven at the rising edge
    logic rsp_valid_next = 1'b0;
    logic rsp_mdata_next = 1'b0;
    logic almfull_next = 1'b0;
    logic almfull_on = 1'b0;

    int cycle = 0;
    int beats_seen = 0;
    int rsp_seen = 0;
    int wait_seen = 0;
    int wait_base = 0;
    int bursts_sent = 0;
    int beat_errors = 0;
    int flow_errors = 0;
    int errors_before = 0;
    int tests_run = 0;
    int final_errors;
    int i;

    t_line_addr rnd_addr[RAND_BURSTS];
    int         rnd_len[RAND_BURSTS];

    always #50 clk = ~clk;

    hmem_wr_top UUT
    (
        .clk                   (clk),
        .reset                 (reset),
        .wr_write              (wr_write),
        .wr_address            (wr_address),
        .wr_burstcount         (wr_burstcount),
        .wr_writedata          (wr_writedata),
        .wr_function           (wr_function),
        .wr_waitrequest        (wr_waitrequest),
        .wr_writeresponsevalid (wr_writeresponsevalid),
        .c1_valid              (c1_valid),
        .c1_address            (c1_address),
        .c1_cl_len             (c1_cl_len),
        .c1_sop                (c1_sop),
        .c1_fence              (c1_fence),
        .c1_data               (c1_data),
        .c1_mdata              (c1_mdata),
        .c1_almfull            (c1_almfull),
        .c1_rsp_valid          (c1_rsp_valid),
        .c1_rsp_mdata          (c1_rsp_mdata)
    );

    // Host protocol checks ride along inside the top level
    bind hmem_wr_top hmem_wr_sva u_sva
    (
        .clk                   (clk),
        .reset                 (reset),
        .c1_valid              (c1_valid),
        .c1_address            (c1_address),
        .c1_cl_len             (c1_cl_len),
        .c1_sop                (c1_sop),
        .c1_fence              (c1_fence),
        .c1_almfull            (c1_almfull),
        .c1_rsp_valid          (c1_rsp_valid),
        .c1_rsp_mdata          (c1_rsp_mdata),
        .wr_writeresponsevalid (wr_writeresponsevalid)
    );

    // ============================================================
    // Checking helpers
    // ============================================================

    function automatic int check_field(input string name, input logic [63:0] got,
                                       input logic [63:0] expected);
        int bad;
        bad = 0;
        assert (got == expected)
        else
        begin
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
            bad = 1;
        end
        return bad;
    endfunction

    function automatic int total_errors();
        return beat_errors + flow_errors + UUT.u_sva.fail_count;
    endfunction

    // A chunk takes 4 lines when aligned to 4 with 4 left, else 2 when even with 2 left
    // Only the chunk that ends the burst wants a response
    function automatic void predict_chunks(input t_line_addr addr, input int count,
                                           input bit fence);
        t_line_addr a;
        int left;
        int n;
        int k;
        a = addr;
        left = count;
        while (left > 0)
        begin
            if ((a[1:0] == 2'b00) && (left >= 4))
            begin
                n = 4;
            end
            else if (!a[0] && (left >= 2))
            begin
                n = 2;
            end
            else
            begin
                n = 1;
            end
            for (k = 0; k < n; k++)
            begin
                exp_addr.push_back(a + t_line_addr'(k));
                exp_len.push_back(t_cl_len'(n - 1));
                exp_sop.push_back(k == 0);
                exp_fence.push_back(fence);
                exp_mdata.push_back(left == n);
            end
            a = a + t_line_addr'(n);
            left = left - n;
        end
    endfunction

    // ============================================================
    // AFU driver
    // ============================================================

    task automatic send_burst(input t_line_addr addr, input int count, input bit fence,
                              input bit gaps);
        int beat;
        int waits;
        bit stuck;
        t_line_data data;
        stuck = 0;
        predict_chunks(addr, count, fence);
        bursts_sent++;
        for (beat = 0; (beat < count) && !stuck; beat++)
        begin
            @(posedge clk);
            // An idle cycle now and then keeps the splitter honest about gaps
            if (gaps && ($unsigned($random(seed)) % 4 == 0))
            begin
                wr_write <= 1'b0;
                @(posedge clk);
            end
            data[63:32] = $random(seed);
            data[31:0] = $random(seed);
            exp_data.push_back(data);
            wr_write <= 1'b1;
            wr_address <= addr;
            wr_burstcount <= t_afu_burst'(count);
            wr_function <= fence;
            wr_writedata <= data;

            // The beat is taken at the next rising edge once waitrequest is low
            waits = 0;
            @(negedge clk);
            while (wr_waitrequest && (waits < WAIT_LIMIT))
            begin
                @(negedge clk);
                waits++;
            end
            if (wr_waitrequest)
            begin
                $display("AFU beat %0d at line %0h stuck behind waitrequest at %0t ns",
                         beat, addr, $time);
                flow_errors++;
                stuck = 1;
            end
        end
        @(posedge clk);
        wr_write <= 1'b0;
    endtask

    // Waits for every expected beat and response, then reports the test
    task automatic finish_test(input string name);
        int waits;
        int now_errors;
        waits = 0;
        while (((exp_sop.size() != 0) || (pend_due.size() != 0) || (rsp_seen != bursts_sent))
               && (waits < DRAIN_LIMIT))
        begin
            @(posedge clk);
            waits++;
        end
        if (waits >= DRAIN_LIMIT)
        begin
            $display("test %0d timed out waiting for host beats and responses", tests_run + 1);
            flow_errors++;
        end
        flow_errors += check_field("missing host beats", 64'(exp_sop.size()), 64'(0));
        flow_errors += check_field("wr_writeresponsevalid count", 64'(rsp_seen),
                                   64'(bursts_sent));
        tests_run++;
        now_errors = total_errors();
        $display("test %0d (%s) done with %0d errors", tests_run, name, now_errors - errors_before);
        errors_before = now_errors;
    endtask

    // ============================================================
    // Host model and scoreboard
    // ============================================================

    always @(negedge clk)
    begin
        cycle++;
        if (!reset && c1_valid)
        begin
            beats_seen++;
            if (exp_sop.size() == 0)
            begin
                $display("unexpected host beat at %0t ns, address %0h", $time, c1_address);
                beat_errors++;
            end
            else
            begin
                // A fence carries no line address toward the host
                if (!exp_fence[0])
                begin
                    beat_errors += check_field("c1_address", 64'(c1_address), 64'(exp_addr[0]));
                end
                beat_errors += check_field("c1_cl_len", 64'(c1_cl_len), 64'(exp_len[0]));
                beat_errors += check_field("c1_sop", 64'(c1_sop), 64'(exp_sop[0]));
                beat_errors += check_field("c1_fence", 64'(c1_fence), 64'(exp_fence[0]));
                beat_errors += check_field("c1_mdata", 64'(c1_mdata), 64'(exp_mdata[0]));
                beat_errors += check_field("c1_data", c1_data, exp_data[0]);
                void'(exp_addr.pop_front());
                void'(exp_len.pop_front());
                void'(exp_sop.pop_front());
                void'(exp_fence.pop_front());
                void'(exp_mdata.pop_front());
                void'(exp_data.pop_front());
            end
            // Each chunk header earns one host response echoing its mdata
            if (c1_sop)
            begin
                pend_mdata.push_back(c1_mdata);
                pend_due.push_back(cycle + 1 + int'($unsigned($random(seed)) % 4));
            end
        end
        if (!reset && wr_writeresponsevalid)
        begin
            rsp_seen++;
        end
        if (wr_write && wr_waitrequest)
        begin
            wait_seen++;
        end

        if ((pend_due.size() != 0) && (pend_due[0] <= cycle))
        begin
            rsp_valid_next = 1'b1;
            rsp_mdata_next = pend_mdata.pop_front();
            void'(pend_due.pop_front());
        end
        else
        begin
            rsp_valid_next = 1'b0;
            rsp_mdata_next = 1'b0;
        end
        almfull_next = almfull_on && ($unsigned($random(seed)) % 4 != 0);
    end

    always @(posedge clk)
    begin
        c1_rsp_valid <= rsp_valid_next;
        c1_rsp_mdata <= rsp_mdata_next;
        c1_almfull <= almfull_next;
    end

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin
        reset = 1'b1;
        wr_write = 1'b0;
        wr_address = '0;
        wr_burstcount = '0;
        wr_writedata = '0;
        wr_function = 1'b0;

        // Random burst shapes are fixed up front from the seed
        for (i = 0; i < RAND_BURSTS; i++)
        begin
            rnd_addr[i] = t_line_addr'($random(seed));
            rnd_len[i] = 1 + int'($unsigned($random(seed)) % 16);
        end

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        send_burst(16'h0005, 1, 1'b0, 1'b0);
        send_burst(16'h0008, 1, 1'b0, 1'b0);
        send_burst(16'h0003, 1, 1'b0, 1'b0);
        finish_test("single-line writes");

        send_burst(16'h0020, 4, 1'b0, 1'b0);
        finish_test("aligned 4-line burst");

        send_burst(16'h0001, 7, 1'b0, 1'b0);
        finish_test("7-line burst from line 1");

        send_burst(16'h0040, 1, 1'b1, 1'b0);
        finish_test("write fence");

        // Heavy almost-full so the FIFO fills and waitrequest must rise
        @(posedge clk);
        wait_base <= wait_seen;
        almfull_on <= 1'b1;
        for (i = 0; i < RAND_BURSTS; i++)
        begin
            send_burst(rnd_addr[i], rnd_len[i], 1'b0, 1'b1);
        end
        @(posedge clk);
        almfull_on <= 1'b0;
        assert (wait_seen > wait_base)
        else
        begin
            $display("waitrequest never rose while the beat FIFO was full");
            flow_errors++;
        end
        finish_test("random bursts under almfull");

        final_errors = total_errors();
        $display("tests %0d, host beats %0d, responses %0d, errors %0d",
                 tests_run, beats_seen, rsp_seen, final_errors);
        if (final_errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
